// ==== tb.f ====
+incdir+hdl
hdl/corr_sample_pkg.sv
hdl/corr_vis_pkg.sv
hdl/pair_decoder.sv
hdl/cos_sin_accumulator.sv
hdl/visibility_unloader.sv
hdl/correlator_top.sv
tb/tb_clock.sv
tb/tb_correlator.sv

// ==== tb/tb_correlator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_params.svh"

module tb_correlator
   import corr_sample_pkg::*;
   import corr_vis_pkg::*;
();

   localparam int NUM_INTEG      = 5;
   localparam int NA             = `CORR_NUM_ANT;
   localparam int NP             = `CORR_NUM_PAIRS;
   localparam int NS             = `CORR_INTEG_SAMPLES;
   localparam int ACC_MAX        = (1 << `CORR_ACCUM_BITS) - 1;
   localparam int TOTAL_ENTRIES  = NUM_INTEG * NP;
   localparam int TIMEOUT_CYCLES = NUM_INTEG * NS * NP * 2 + 500;
   // Integration driven with all-zero samples
   localparam int ZERO_INTEG     = 1;
   // Integration during which the previous results are held back
   localparam int STALL_INTEG    = 2;
   localparam logic [NP*10-1:0] PAIR_TABLE = `CORR_PAIR_TABLE;

   logic          clk_x;
   logic          rst_n;
   logic          in_valid;
   logic          in_ready;
   corr_sample_t  in_sample;
   logic          out_valid;
   logic          out_ready;
   corr_vis_t     out_vis;

   // Driven sample is the closing one of its integration
   logic          closing_q;
   logic [31:0]   lfsr_q = 32'h8e3c;
   int            cycle_cnt = 0;
   int            rx_count = 0;
   // Expected visibilities, oldest integration first
   corr_vis_t     exp_q[$];
   // Reference counts of the running integration
   int            m_cos [NP];
   int            m_sin [NP];
   bit            m_ovf_cos [NP];
   bit            m_ovf_sin [NP];
   bit            hold_pending = 1'b0;
   corr_vis_t     held_vis;
   // Output kept stalled until the next closing sample is pending
   bit            drain_hold = 1'b0;

   tb_clock u_clock (
      .clk_x (clk_x),
      .rst_n (rst_n)
   );

   correlator_top u_dut (
      .clk_x     (clk_x),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_sample (in_sample),
      .out_ready (out_ready),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_vis   (out_vis)
   );

   // ------------------------------------------------------------------------
   // Random source, Galois LFSR stepped once per bit
   // ------------------------------------------------------------------------
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   task automatic check_value(input string name, input int expected, input int actual);
      if (expected != actual) begin
         $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, expected,
                  actual);
         $display("STATUS: FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // ------------------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------------------
   task automatic sat_count(inout int cnt, inout bit ovf, input bit hit);
      // Count holds at maximum, flag sticks
      if (hit) begin
         if (cnt == ACC_MAX)
            ovf = 1'b1;
         else
            cnt = cnt + 1;
      end
   endtask

   task automatic model_sample(input corr_sample_t smp, input int s_idx);
      logic [9:0] entry;
      int         a;
      int         b;
      corr_vis_t  vis;
      for (int p = 0; p < NP; p++) begin
         entry = PAIR_TABLE[p*10 +: 10];
         a     = entry[4:0];
         b     = entry[9:5];
         // Fresh start on the first sample
         if (s_idx == 0) begin
            m_cos[p]     = 0;
            m_sin[p]     = 0;
            m_ovf_cos[p] = 1'b0;
            m_ovf_sin[p] = 1'b0;
         end
         sat_count(m_cos[p], m_ovf_cos[p], smp.re[a] == smp.re[b]);
         sat_count(m_sin[p], m_ovf_sin[p], smp.re[a] == smp.im[b]);
         if (s_idx == NS - 1) begin
            vis.pair    = 4'(p);
            vis.cos_cnt = 5'(m_cos[p]);
            vis.sin_cnt = 5'(m_sin[p]);
            vis.ovf_cos = m_ovf_cos[p];
            vis.ovf_sin = m_ovf_sin[p];
            exp_q.push_back(vis);
         end
      end
   endtask

   // One clock, with a fresh out_ready draw (low about 3 in 8)
   // Forced low while the output is held back
   task automatic step_cycle();
      @(posedge clk_x);
      out_ready <= !drain_hold && (rand_bits(3) >= 3);
   endtask

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   initial begin
      corr_sample_t smp;
      in_valid  = 1'b0;
      in_sample = '0;
      out_ready = 1'b0;
      closing_q = 1'b0;
      @(posedge clk_x);
      while (!rst_n)
         @(posedge clk_x);
      for (int n = 0; n < NUM_INTEG; n++) begin
         // Previous results stay undrained up to this closing sample
         drain_hold = (n == STALL_INTEG);
         for (int s = 0; s < NS; s++) begin
            if (n == ZERO_INTEG) begin
               smp = '0;
            end else begin
               smp.re = NA'(rand_bits(NA));
               smp.im = NA'(rand_bits(NA));
            end
            model_sample(smp, s);
            // Idle gap, about one cycle in four
            while (rand_bits(2) == 0) begin
               in_valid <= 1'b0;
               step_cycle();
            end
            in_valid  <= 1'b1;
            in_sample <= smp;
            closing_q <= (s == NS - 1);
            step_cycle();
            // Closing sample pending against a full buffer
            if (drain_hold && s == NS - 1) begin
               repeat (NP) step_cycle();
               drain_hold = 1'b0;
            end
            // Held until taken
            while (!in_ready)
               step_cycle();
         end
      end
      in_valid  <= 1'b0;
      closing_q <= 1'b0;
      while (rx_count < TOTAL_ENTRIES)
         step_cycle();
      // Quiet period, nothing extra may come out
      repeat (2 * NP) step_cycle();
      $display("STATUS: PASS");
      $finish;
   end

   // ------------------------------------------------------------------------
   // Output monitor
   // ------------------------------------------------------------------------
   task automatic receive_entry(input corr_vis_t got);
      corr_vis_t exp;
      if (exp_q.size() == 0) begin
         $display("Output transfer at %0t ns with no visibility expected", $time);
         $display("STATUS: FAIL");
         $fatal(1, "extra output entry");
      end else begin
         exp = exp_q.pop_front();
         // Pair order 0 to 11 in every integration
         check_value("out_vis.pair", rx_count % NP, got.pair);
         check_value("out_vis.cos_cnt", exp.cos_cnt, got.cos_cnt);
         check_value("out_vis.sin_cnt", exp.sin_cnt, got.sin_cnt);
         check_value("out_vis.ovf_cos", exp.ovf_cos, got.ovf_cos);
         check_value("out_vis.ovf_sin", exp.ovf_sin, got.ovf_sin);
         // All-zero run saturates both terms
         if (rx_count / NP == ZERO_INTEG) begin
            check_value("zero run cos_cnt", ACC_MAX, got.cos_cnt);
            check_value("zero run sin_cnt", ACC_MAX, got.sin_cnt);
            check_value("zero run ovf_cos", 1, got.ovf_cos);
            check_value("zero run ovf_sin", 1, got.ovf_sin);
         end
         rx_count = rx_count + 1;
      end
   endtask

   always @(posedge clk_x) begin
      if (rst_n) begin
         // Stalled entry stays put
         if (hold_pending) begin
            check_value("out_valid", 1, out_valid);
            check_value("out_vis", held_vis, out_vis);
         end
         if (out_valid && out_ready)
            receive_entry(out_vis);
         // Closing sample refused while results still drain
         if (out_valid && in_valid && closing_q)
            check_value("in_ready", 0, in_ready);
         hold_pending = out_valid && !out_ready;
         held_vis     = out_vis;
      end
   end

   // Run limit
   always @(posedge clk_x) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, only %0d entries received", cycle_cnt,
                  rx_count);
         $display("STATUS: FAIL");
         $fatal(1, "timeout");
      end
   end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and power-on reset
module tb_clock #(
   parameter int half_period  = 20,
   parameter int reset_cycles = 3
) (
   output logic clk_x,
   output logic rst_n
);

   initial begin
      clk_x = 1'b0;
      forever #(half_period) clk_x = ~clk_x;
   end

   // Released on a rising edge after the hold time
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk_x);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== hdl/correlator_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_params.svh"

module correlator_top
   import corr_sample_pkg::*;
   import corr_vis_pkg::*;
#(
   parameter int integ_samples = `CORR_INTEG_SAMPLES
) (
   input  wire logic          clk_x,
   input  wire logic          rst_n,
   input  wire logic          in_valid,
   input  wire corr_sample_t  in_sample,
   input  wire logic          out_ready,
   output logic               in_ready,
   output logic               out_valid,
   output corr_vis_t          out_vis
);

   // Decoder to accumulator, always accepted
   logic           op_valid;
   corr_pair_op_t  op;

   // Accumulator to unloader, closing sample only
   logic           res_valid;
   corr_vis_t      res;

   // Unloader holds off the next closing sample
   logic           unl_busy;

   // ------------------------------------------------------------------------
   // Sample to pair operations
   // ------------------------------------------------------------------------
   pair_decoder #(
      .integ_samples (integ_samples)
   ) u_pair_decoder (
      .clk_x     (clk_x),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_sample (in_sample),
      .unl_busy  (unl_busy),
      .in_ready  (in_ready),
      .op_valid  (op_valid),
      .op        (op)
   );

   // Read-add-write over the pair accumulators
   cos_sin_accumulator u_cos_sin_accumulator (
      .clk_x     (clk_x),
      .rst_n     (rst_n),
      .op_valid  (op_valid),
      .op        (op),
      .res_valid (res_valid),
      .res       (res)
   );

   // Output buffer and stream
   visibility_unloader u_visibility_unloader (
      .clk_x     (clk_x),
      .rst_n     (rst_n),
      .res_valid (res_valid),
      .res       (res),
      .out_ready (out_ready),
      .out_valid (out_valid),
      .out_vis   (out_vis),
      .unl_busy  (unl_busy)
   );

endmodule

`default_nettype wire

// ==== hdl/visibility_unloader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_params.svh"

module visibility_unloader
   import corr_vis_pkg::*;
(
   input  wire logic       clk_x,
   input  wire logic       rst_n,
   input  wire logic       res_valid,
   input  wire corr_vis_t  res,
   input  wire logic       out_ready,
   output logic            out_valid,
   output corr_vis_t       out_vis,
   output logic            unl_busy
);

   localparam int PB = `CORR_PAIR_BITS;
   localparam int NP = `CORR_NUM_PAIRS;

   localparam logic [PB-1:0] LAST_PAIR = PB'(NP - 1);

   corr_vis_t        vis_buf [0:NP-1];
   unloader_state_e  state;
   logic [PB-1:0]    rd_ptr;
   logic             xfer;
   logic             fill_done;

   // ------------------------------------------------------------------------
   // Result buffer, written by pair index
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (res_valid)
         vis_buf[res.pair] <= res;
   end

   // Last pair written, drain starts next cycle
   assign fill_done = res_valid && (res.pair == LAST_PAIR);

   // Handshake on the output stream
   assign xfer = out_valid && out_ready;

   // ------------------------------------------------------------------------
   // Fill and drain control
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         state    <= UNL_FILL;
         rd_ptr   <= '0;
         unl_busy <= 1'b0;
      end else begin
         case (state)
            UNL_FILL: begin
               // Busy from the first write of an integration
               if (res_valid)
                  unl_busy <= 1'b1;
               if (fill_done) begin
                  state  <= UNL_DRAIN;
                  rd_ptr <= '0;
               end
            end
            UNL_DRAIN: begin
               if (xfer) begin
                  if (rd_ptr == LAST_PAIR) begin
                     // All entries gone, release the decoder
                     state    <= UNL_FILL;
                     unl_busy <= 1'b0;
                  end else begin
                     rd_ptr <= rd_ptr + 1'b1;
                  end
               end
            end
            default: state <= UNL_FILL;
         endcase
      end
   end

   // Entry held steady until accepted
   assign out_valid = (state == UNL_DRAIN);
   assign out_vis   = vis_buf[rd_ptr];

endmodule

`default_nettype wire

// ==== hdl/cos_sin_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_params.svh"

module cos_sin_accumulator
   import corr_sample_pkg::*;
   import corr_vis_pkg::*;
(
   input  wire logic           clk_x,
   input  wire logic           rst_n,
   input  wire logic           op_valid,
   input  wire corr_pair_op_t  op,
   output logic                res_valid,
   output corr_vis_t           res
);

   localparam int ACC = `CORR_ACCUM_BITS;
   localparam int NP  = `CORR_NUM_PAIRS;

   localparam logic [ACC-1:0] ACC_MAX = {ACC{1'b1}};

   // Stored state per pair
   typedef struct packed {
      logic [ACC-1:0] cos_cnt;
      logic [ACC-1:0] sin_cnt;
      logic           ovf_cos;
      logic           ovf_sin;
   } acc_entry_t;

   acc_entry_t     acc_mem [0:NP-1];

   logic           s1_valid;
   corr_pair_op_t  s1_op;
   acc_entry_t     s1_entry;
   acc_entry_t     base;
   acc_entry_t     upd;
   logic           hit_cos;
   logic           hit_sin;

   // Saturating increment, result is {overflow, count}
   function automatic logic [ACC:0] sat_inc(input logic [ACC-1:0] cnt,
                                            input logic           ovf,
                                            input logic           hit);
      logic [ACC-1:0] cnt_new;
      logic           ovf_new;
      cnt_new = cnt;
      ovf_new = ovf;
      if (hit) begin
         // Hold at maximum, flag stays set
         if (cnt == ACC_MAX)
            ovf_new = 1'b1;
         else
            cnt_new = cnt + 1'b1;
      end
      return {ovf_new, cnt_new};
   endfunction

   // ------------------------------------------------------------------------
   // Stage 1, read the stored counts of the pair
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (op_valid) begin
         s1_op    <= op;
         s1_entry <= acc_mem[op.pair];
      end
   end

   // ------------------------------------------------------------------------
   // Stage 2, compare, add and write back
   // ------------------------------------------------------------------------
   // First sample of an integration starts from zero
   assign base = (s1_op.op == OP_FIRST) ? '0 : s1_entry;

   // Cosine when both real bits agree
   // Sine when real of a agrees with imaginary of b
   assign hit_cos = (s1_op.ar == s1_op.br);
   assign hit_sin = (s1_op.ar == s1_op.bi);

   always_comb begin
      {upd.ovf_cos, upd.cos_cnt} = sat_inc(base.cos_cnt, base.ovf_cos, hit_cos);
      {upd.ovf_sin, upd.sin_cnt} = sat_inc(base.sin_cnt, base.ovf_sin, hit_sin);
   end

   always_ff @(posedge clk_x) begin
      if (s1_valid)
         acc_mem[s1_op.pair] <= upd;
   end

   // Finished visibility, only on the closing sample
   always_ff @(posedge clk_x) begin
      if (s1_valid && s1_op.op == OP_LAST) begin
         res.pair    <= s1_op.pair;
         res.cos_cnt <= upd.cos_cnt;
         res.sin_cnt <= upd.sin_cnt;
         res.ovf_cos <= upd.ovf_cos;
         res.ovf_sin <= upd.ovf_sin;
      end
   end

   // Valid pipeline
   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid  <= 1'b0;
         res_valid <= 1'b0;
      end else begin
         s1_valid  <= op_valid;
         res_valid <= s1_valid && (s1_op.op == OP_LAST);
      end
   end

endmodule

`default_nettype wire

// ==== hdl/pair_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "corr_params.svh"

module pair_decoder
   import corr_sample_pkg::*;
#(
   parameter int integ_samples = `CORR_INTEG_SAMPLES
) (
   input  wire logic          clk_x,
   input  wire logic          rst_n,
   input  wire logic          in_valid,
   input  wire corr_sample_t  in_sample,
   input  wire logic          unl_busy,
   output logic               in_ready,
   output logic               op_valid,
   output corr_pair_op_t      op
);

   localparam int PB        = `CORR_PAIR_BITS;
   localparam int NP        = `CORR_NUM_PAIRS;
   localparam int SAMP_BITS = $clog2(integ_samples);

   localparam logic [PB-1:0]        LAST_PAIR  = PB'(NP - 1);
   localparam logic [SAMP_BITS-1:0] LAST_SAMP  = SAMP_BITS'(integ_samples - 1);
   localparam logic [NP*10-1:0]     PAIR_TABLE = `CORR_PAIR_TABLE;

   decoder_state_e         state, nxt_state;
   logic [PB-1:0]          pair_cnt, nxt_cnt;
   logic [SAMP_BITS-1:0]   samp_cnt, nxt_samp;
   corr_op_e               op_kind, nxt_kind;
   corr_sample_t           sample_q;
   logic                   accept;
   logic                   ready_nxt;
   logic [9:0]             entry;
   logic [4:0]             a_idx;
   logic [4:0]             b_idx;

   assign accept = in_valid & in_ready;

   // ------------------------------------------------------------------------
   // Sequencing of pairs and samples
   // ------------------------------------------------------------------------
   always_comb begin
      nxt_state = state;
      nxt_cnt   = pair_cnt;
      nxt_samp  = samp_cnt;
      nxt_kind  = op_kind;
      if (accept) begin
         // New sample, restart at pair 0
         nxt_state = DEC_STEP;
         nxt_cnt   = '0;
         nxt_samp  = (samp_cnt == LAST_SAMP) ? '0 : samp_cnt + 1'b1;
         // Kind follows the sample's place in the integration
         if (samp_cnt == '0)
            nxt_kind = OP_FIRST;
         else if (samp_cnt == LAST_SAMP)
            nxt_kind = OP_LAST;
         else
            nxt_kind = OP_ACCUM;
      end else if (state == DEC_STEP) begin
         if (pair_cnt == LAST_PAIR)
            nxt_state = DEC_IDLE;
         else
            nxt_cnt = pair_cnt + 1'b1;
      end
   end

   // Ready while idle or on the final pair
   // Closing sample waits until the previous results have drained
   assign ready_nxt = (nxt_state == DEC_IDLE || nxt_cnt == LAST_PAIR) &&
                      !(nxt_samp == LAST_SAMP && unl_busy);

   always_ff @(posedge clk_x or negedge rst_n) begin
      if (!rst_n) begin
         state    <= DEC_IDLE;
         pair_cnt <= '0;
         samp_cnt <= '0;
         op_kind  <= OP_FIRST;
         in_ready <= 1'b0;
      end else begin
         state    <= nxt_state;
         pair_cnt <= nxt_cnt;
         samp_cnt <= nxt_samp;
         op_kind  <= nxt_kind;
         in_ready <= ready_nxt;
      end
   end

   // Held sample, stays until the next acceptance
   always_ff @(posedge clk_x) begin
      if (accept)
         sample_q <= in_sample;
   end

   // ------------------------------------------------------------------------
   // Pair table lookup and bit selection
   // ------------------------------------------------------------------------
   assign entry = PAIR_TABLE[pair_cnt*10 +: 10];
   assign a_idx = entry[4:0];
   assign b_idx = entry[9:5];

   assign op_valid = (state == DEC_STEP);

   always_comb begin
      op.pair = pair_cnt;
      op.op   = op_kind;
      op.ar   = sample_q.re[a_idx];
      op.br   = sample_q.re[b_idx];
      op.bi   = sample_q.im[b_idx];
   end

endmodule

`default_nettype wire

// ==== hdl/corr_vis_pkg.sv ====
`default_nettype none

`include "corr_params.svh"

// ---------------------------------------------------------------------------
// Output side of the correlator, finished visibilities
// ---------------------------------------------------------------------------
package corr_vis_pkg;

   // Visibility of one pair over one integration
   // Flags are sticky once a count hits its maximum
   typedef struct packed {
      logic [`CORR_PAIR_BITS-1:0]  pair;
      logic [`CORR_ACCUM_BITS-1:0] cos_cnt;
      logic [`CORR_ACCUM_BITS-1:0] sin_cnt;
      logic                        ovf_cos;
      logic                        ovf_sin;
   } corr_vis_t;

   // Buffer collects results, then streams them out
   typedef enum logic {
      UNL_FILL  = 1'b0,
      UNL_DRAIN = 1'b1
   } unloader_state_e;

endpackage

`default_nettype wire

// ==== hdl/corr_sample_pkg.sv ====
`default_nettype none

`include "corr_params.svh"

// ---------------------------------------------------------------------------
// Input side of the correlator, antenna samples and pair operations
// ---------------------------------------------------------------------------
package corr_sample_pkg;

   // One-bit quadrature sample of every antenna
   typedef struct packed {
      logic [`CORR_NUM_ANT-1:0] re;
      logic [`CORR_NUM_ANT-1:0] im;
   } corr_sample_t;

   // Position of a sample within its integration
   typedef enum logic [1:0] {
      OP_FIRST = 2'd0,
      OP_ACCUM = 2'd1,
      OP_LAST  = 2'd2
   } corr_op_e;

   // One pair of one sample, as handed to the accumulator
   typedef struct packed {
      logic [`CORR_PAIR_BITS-1:0] pair;
      corr_op_e                   op;
      logic                       ar;
      logic                       br;
      logic                       bi;
   } corr_pair_op_t;

   typedef enum logic {
      DEC_IDLE = 1'b0,
      DEC_STEP = 1'b1
   } decoder_state_e;

endpackage

`default_nettype wire

// ==== hdl/corr_params.svh ====
`ifndef CORR_PARAMS_SVH
`define CORR_PARAMS_SVH

// Array size and pairs correlated per accepted sample
`define CORR_NUM_ANT        24
`define CORR_NUM_PAIRS      12
`define CORR_PAIR_BITS      4

// Cosine and sine count width, saturates at 31
`define CORR_ACCUM_BITS     5

// Pair table, twelve 10-bit entries of {b index, a index}
// Entry 0 in the low bits, entry 11 in the high bits
// Pairs (a,b): (0,1) (0,2) (1,2) (3,4) (5,6) (7,8) (9,10)
//              (11,12) (13,14) (15,16) (17,20) (21,23)
`define CORR_PAIR_TABLE     {5'd23, 5'd21, 5'd20, 5'd17, 5'd16, 5'd15, \
                             5'd14, 5'd13, 5'd12, 5'd11, 5'd10, 5'd9,  \
                             5'd8,  5'd7,  5'd6,  5'd5,  5'd4,  5'd3,  \
                             5'd2,  5'd1,  5'd2,  5'd0,  5'd1,  5'd0}

// Samples per integration, at least 2
`define CORR_INTEG_SAMPLES  40

`endif
